// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [reg_addr_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]       word_t;

    localparam word_t reset_pc = 32'h0000_0000;  // First fetch address

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_addi  = 6'h08;

    // R-type funct, instr[5:0]
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_pass_b = 3'd4  // Jump target passthrough
    } alu_op_t;

    // Decode to execute
    typedef struct packed {
        word_t    pc;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;      // Sign extended, or full jump target for j
        alu_op_t  alu_op;
        logic     use_imm;  // Operand b from imm instead of rt
        logic     branch;   // beq
        logic     jump;     // j
        reg_idx_t rd;       // Zero for non-writers
        logic     we;
    } id_ex_t;

    // Execute to MEM
    typedef struct packed {
        reg_idx_t rd;
        logic     we;
        word_t    result;
    } ex_mem_t;

    // MEM to writeback, same layout
    typedef struct packed {
        reg_idx_t rd;
        logic     we;
        word_t    result;
    } mem_wb_t;

endpackage

// ==== hdl/fetch_if.sv ====
`timescale 1ns/1ps

// Fetch to decode handoff
interface fetch_if import pipe_pkg::*; ();

    logic  valid;  // Word offered
    word_t instr;
    word_t pc;     // Address of instr
    logic  hold;   // Decode cannot take the word this cycle
    logic  flush;  // Offered word is on the wrong path

    // Transfer on valid && !hold
    modport fetch (
        output valid, instr, pc,
        input  hold, flush
    );

    modport decode (
        input  valid, instr, pc,
        output hold, flush
    );

endinterface

// ==== hdl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     hold,      // Keep contents
    input  logic     flush,     // Drop contents, valid only
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;  // Bubble
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // Payload follows valid, no reset
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    // Stage control never asks for both
    a_hold_flush: assert property (@(posedge clk) disable iff (rst)
        !(hold && flush));

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    output logic   ibus_cyc,
    output logic   ibus_stb,
    output word_t  ibus_adr,
    input  word_t  ibus_dat_r,
    input  logic   ibus_ack,
    fetch_if.fetch fq,
    input  logic   pc_update,   // Redirect from execute
    input  word_t  target_pc,
    input  logic   pc_hazard    // Branch in flight, no new requests
);

    word_t pc;          // Next address to request
    word_t req_adr;     // Address of the request on the bus
    logic  busy;        // Request outstanding
    logic  drop;        // Outstanding response is stale
    logic  buf_valid;
    word_t buf_instr;
    word_t buf_pc;
    logic  take;
    logic  start;
    logic  resp_ok;

    assign take = buf_valid && !fq.hold;

    // One request at a time, only into an empty or draining buffer
    assign start = !busy && !pc_hazard && !pc_update && (!buf_valid || take);

    // Keep the returned word unless it is on a dead path
    assign resp_ok = busy && ibus_ack && !drop && !pc_update && !fq.flush;

    assign ibus_cyc = busy;
    assign ibus_stb = busy;
    assign ibus_adr = req_adr;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            drop <= 1'b0;
            pc   <= reset_pc;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (busy && ibus_ack) begin
                busy <= 1'b0;  // Idle one cycle after ack
            end
            if (busy && ibus_ack) begin
                drop <= 1'b0;
            end else if (busy && pc_update) begin
                drop <= 1'b1;  // Redirect while waiting
            end
            if (pc_update) begin
                pc <= target_pc;
            end else if (start) begin
                pc <= pc + xlen'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_adr <= pc;
        end
    end

    // Single-word buffer toward decode
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (fq.flush) begin
            buf_valid <= 1'b0;
        end else if (resp_ok) begin
            buf_valid <= 1'b1;
        end else if (take) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_ok) begin
            buf_instr <= ibus_dat_r;
            buf_pc    <= req_adr;
        end
    end

    assign fq.valid = buf_valid;
    assign fq.instr = buf_instr;
    assign fq.pc    = buf_pc;

    // Slave answers only an open strobe
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ibus_ack |-> ibus_cyc && ibus_stb);

    // Slave sees a fixed address until it acks
    a_adr_stable: assert property (@(posedge clk) disable iff (rst)
        ibus_stb && !ibus_ack |=> $stable(ibus_adr));

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t if_id_rs,    // Zero when not read
    input  reg_idx_t if_id_rt,
    input  reg_idx_t id_ex_rd,
    input  reg_idx_t ex_mem_rd,
    input  reg_idx_t mem_wb_rd,
    input  logic     id_ex_we,
    input  logic     ex_mem_we,
    input  logic     mem_wb_we,
    input  logic     jump_dec,    // j leaving decode
    input  logic     branch_dec,  // beq leaving decode
    input  logic     pc_update,   // Execute resolved the redirect
    output logic     data_hazard,
    output logic     pc_hazard
);

    logic hit_id_ex;
    logic hit_ex_mem;
    logic hit_mem_wb;

    // Source matches a pending write, r0 never pending
    function automatic logic src_hit(reg_idx_t src, reg_idx_t dst, logic we);
        return we && (dst != '0) && (src == dst);
    endfunction

    // No forwarding, so any pending write stalls decode
    assign hit_id_ex  = src_hit(if_id_rs, id_ex_rd, id_ex_we) ||
                        src_hit(if_id_rt, id_ex_rd, id_ex_we);
    assign hit_ex_mem = src_hit(if_id_rs, ex_mem_rd, ex_mem_we) ||
                        src_hit(if_id_rt, ex_mem_rd, ex_mem_we);
    assign hit_mem_wb = src_hit(if_id_rs, mem_wb_rd, mem_wb_we) ||
                        src_hit(if_id_rt, mem_wb_rd, mem_wb_we);

    assign data_hazard = hit_id_ex || hit_ex_mem || hit_mem_wb;

    // Control hazard flag, clear wins
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_hazard <= 1'b0;
        end else if (pc_update) begin
            pc_hazard <= 1'b0;
        end else if (jump_dec || branch_dec) begin
            pc_hazard <= 1'b1;
        end
    end

    // Decode must not release a second jump or branch while one resolves
    a_no_set_on_update: assert property (@(posedge clk) disable iff (rst)
        pc_update |-> !(jump_dec || branch_dec));

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    fetch_if.decode  fq,
    input  logic     data_hazard,
    input  logic     pc_hazard,
    output reg_idx_t rs,          // Sources for the hazard check
    output reg_idx_t rt,
    output logic     jump_dec,
    output logic     branch_dec,
    output logic     ex_valid,
    output id_ex_t   ex_data,
    input  logic     wb_we,
    input  reg_idx_t wb_waddr,
    input  word_t    wb_wdata
);

    logic       if_id_valid;
    word_t      if_id_instr;
    word_t      if_id_pc;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   f_rs;
    reg_idx_t   f_rt;
    reg_idx_t   f_rd;
    logic       reads_rs;
    logic       reads_rt;
    logic       is_ctrl;
    logic       leave;        // IF/ID moves to ID/EX this edge
    logic       accept;       // IF/ID can take the offered word
    word_t      pc_plus4;
    word_t      regs [0:31];

    function automatic word_t rf_read(reg_idx_t a);
        return (a == '0) ? '0 : regs[a];
    endfunction

    assign opcode   = if_id_instr[31:26];
    assign f_rs     = if_id_instr[25:21];
    assign f_rt     = if_id_instr[20:16];
    assign f_rd     = if_id_instr[15:11];
    assign funct    = if_id_instr[5:0];
    assign pc_plus4 = if_id_pc + xlen'(4);

    assign reads_rs = (opcode == op_rtype) || (opcode == op_addi) || (opcode == op_beq);
    assign reads_rt = (opcode == op_rtype) || (opcode == op_beq);  // addi rt is a dest
    assign is_ctrl  = (opcode == op_j) || (opcode == op_beq);

    assign rs = (if_id_valid && reads_rs) ? f_rs : '0;
    assign rt = (if_id_valid && reads_rt) ? f_rt : '0;

    assign leave      = if_id_valid && !data_hazard;
    assign ex_valid   = leave;              // Bubble while stalled
    assign jump_dec   = leave && (opcode == op_j);
    assign branch_dec = leave && (opcode == op_beq);

    // Nothing behind a jump or branch until it resolves
    assign accept   = !pc_hazard && (!if_id_valid || (leave && !is_ctrl));
    assign fq.hold  = !accept;
    assign fq.flush = pc_hazard;  // Offered word is past the branch

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_valid <= 1'b0;
        end else if (pc_hazard) begin
            if_id_valid <= 1'b0;
        end else if (accept && fq.valid) begin
            if_id_valid <= 1'b1;
        end else if (leave) begin
            if_id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && fq.valid) begin
            if_id_instr <= fq.instr;
            if_id_pc    <= fq.pc;
        end
    end

    // Register file, written from WB, r0 stays zero on read
    always_ff @(posedge clk) begin
        if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    always_comb begin
        ex_data        = '0;
        ex_data.pc     = if_id_pc;
        ex_data.rs_val = rf_read(f_rs);
        ex_data.rt_val = rf_read(f_rt);
        ex_data.imm    = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
        case (opcode)
            op_rtype: begin
                ex_data.rd = f_rd;
                ex_data.we = 1'b1;
                case (funct)
                    fn_add: ex_data.alu_op = alu_add;
                    fn_sub: ex_data.alu_op = alu_sub;
                    fn_and: ex_data.alu_op = alu_and;
                    fn_or:  ex_data.alu_op = alu_or;
                    default: begin  // Unknown funct runs as a nop
                        ex_data.rd = '0;
                        ex_data.we = 1'b0;
                    end
                endcase
            end
            op_addi: begin
                ex_data.alu_op  = alu_add;
                ex_data.use_imm = 1'b1;
                ex_data.rd      = f_rt;
                ex_data.we      = 1'b1;
            end
            op_beq: begin
                ex_data.alu_op = alu_sub;  // Equal when difference is zero
                ex_data.branch = 1'b1;
            end
            op_j: begin
                ex_data.alu_op  = alu_pass_b;
                ex_data.use_imm = 1'b1;
                ex_data.jump    = 1'b1;
                ex_data.imm     = {pc_plus4[31:28], if_id_instr[25:0], 2'b00};
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  id_ex_t  in_data,
    output logic    out_valid,   // Instruction leaving EX
    output ex_mem_t out_data,
    output logic    pc_update,
    output word_t   target_pc
);

    word_t op_b;
    word_t result;
    word_t pc_plus4;
    word_t br_target;
    logic  taken;

    assign op_b = in_data.use_imm ? in_data.imm : in_data.rt_val;

    always_comb begin
        case (in_data.alu_op)
            alu_add:    result = in_data.rs_val + op_b;
            alu_sub:    result = in_data.rs_val - op_b;
            alu_and:    result = in_data.rs_val & op_b;
            alu_or:     result = in_data.rs_val | op_b;
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    // Branch resolution
    assign pc_plus4  = in_data.pc + xlen'(4);
    assign br_target = pc_plus4 + {in_data.imm[xlen-3:0], 2'b00};
    assign taken     = in_data.branch && (result == '0);

    assign pc_update = in_valid && (in_data.branch || in_data.jump);
    assign target_pc = in_data.jump ? in_data.imm :
                       taken        ? br_target : pc_plus4;

    assign out_valid = in_valid;

    assign out_data.rd     = in_data.rd;
    assign out_data.we     = in_data.we && !in_data.branch && !in_data.jump;  // beq and j never write
    assign out_data.result = result;

    // One redirect per jump, decode sends nothing behind it
    a_update_pulse: assert property (@(posedge clk) disable iff (rst)
        pc_update |=> !pc_update);

endmodule

// ==== hdl/pipe_core.sv ====
`timescale 1ns/1ps

module pipe_core import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    output logic     ibus_cyc,
    output logic     ibus_stb,
    output word_t    ibus_adr,
    input  word_t    ibus_dat_r,
    input  logic     ibus_ack,
    output logic     rf_we,     // Register write as it retires
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata
);

    fetch_if fq ();

    logic     pc_update;
    word_t    target_pc;
    logic     pc_hazard;
    logic     data_hazard;
    reg_idx_t rs;
    reg_idx_t rt;
    logic     jump_dec;
    logic     branch_dec;
    logic     dec_valid;
    id_ex_t   dec_data;
    logic     id_ex_valid;
    id_ex_t   id_ex_data;
    logic     exe_valid;
    ex_mem_t  exe_data;
    logic     ex_mem_valid;
    ex_mem_t  ex_mem_data;
    logic     mem_wb_valid;
    mem_wb_t  mem_wb_data;
    logic     id_ex_we;       // Pending writes per stage
    logic     ex_mem_we;
    logic     mem_wb_we;

    assign id_ex_we  = id_ex_valid && id_ex_data.we;
    assign ex_mem_we = ex_mem_valid && ex_mem_data.we;
    assign mem_wb_we = mem_wb_valid && mem_wb_data.we;

    assign rf_we    = mem_wb_we;
    assign rf_waddr = mem_wb_data.rd;
    assign rf_wdata = mem_wb_data.result;

    fetch_stage u_fetch (
        .clk(clk), .rst(rst),
        .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
        .ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
        .fq(fq.fetch),
        .pc_update(pc_update), .target_pc(target_pc), .pc_hazard(pc_hazard)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .fq(fq.decode),
        .data_hazard(data_hazard), .pc_hazard(pc_hazard),
        .rs(rs), .rt(rt), .jump_dec(jump_dec), .branch_dec(branch_dec),
        .ex_valid(dec_valid), .ex_data(dec_data),
        .wb_we(mem_wb_we), .wb_waddr(mem_wb_data.rd), .wb_wdata(mem_wb_data.result)
    );

    hazard_unit u_hazard (
        .clk(clk), .rst(rst),
        .if_id_rs(rs), .if_id_rt(rt),
        .id_ex_rd(id_ex_data.rd), .ex_mem_rd(ex_mem_data.rd), .mem_wb_rd(mem_wb_data.rd),
        .id_ex_we(id_ex_we), .ex_mem_we(ex_mem_we), .mem_wb_we(mem_wb_we),
        .jump_dec(jump_dec), .branch_dec(branch_dec), .pc_update(pc_update),
        .data_hazard(data_hazard), .pc_hazard(pc_hazard)
    );

    // EX, MEM and WB never stall
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst(rst), .in_valid(dec_valid), .in_data(dec_data),
        .hold(1'b0), .flush(1'b0), .out_valid(id_ex_valid), .out_data(id_ex_data)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .in_valid(id_ex_valid), .in_data(id_ex_data),
        .out_valid(exe_valid), .out_data(exe_data),
        .pc_update(pc_update), .target_pc(target_pc)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst(rst), .in_valid(exe_valid), .in_data(exe_data),
        .hold(1'b0), .flush(1'b0), .out_valid(ex_mem_valid), .out_data(ex_mem_data)
    );

    // MEM slot only delays the result
    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst(rst), .in_valid(ex_mem_valid), .in_data(ex_mem_data),
        .hold(1'b0), .flush(1'b0), .out_valid(mem_wb_valid), .out_data(mem_wb_data)
    );

endmodule

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Tallies for the closing summary line
int checks_run   = 0;
int value_errors = 0;
int other_errors = 0;

// Single control output
task automatic check_bit(input string name, input logic got, input logic exp);
    checks_run++;
    if (got !== exp) begin
        value_errors++;
        $display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

// Register index of a retired write
task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    checks_run++;
    if (got !== exp) begin
        value_errors++;
        $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
endtask

// Data word of a retired write
task automatic check_word(input string name, input word_t got, input word_t exp);
    checks_run++;
    if (got !== exp) begin
        value_errors++;
        $display("Error at time %0t: %s is %08h, expected %08h", $time, name, got, exp);
    end
endtask

// Anything that is not a value mismatch
task automatic report_failure(input string what);
    other_errors++;
    $display("Failure at time %0t: %s", $time, what);
endtask

`endif

// ==== test/tb_pipe_core.sv ====
`timescale 1ns/1ps

module tb_pipe_core import pipe_pkg::*; ();

    localparam int reset_cycles  = 16;
    localparam int write_timeout = 200;  // Cycles allowed per register write
    localparam int quiet_cycles  = 150;  // Watch window after the last expected write
    localparam int count_at      = 64;   // Golden index of the write count
    localparam int pairs_at      = 65;   // First register, value pair

    logic     clk;
    logic     rst;
    logic     ibus_cyc;
    logic     ibus_stb;
    word_t    ibus_adr;
    word_t    ibus_dat_r;
    logic     ibus_ack;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    word_t      gold [0:127];       // Program, write count, expected writes
    logic [1:0] delay_tab [0:255];  // Ack delay per bus request
    logic [7:0] req_num;            // Requests served so far
    logic [1:0] wait_cnt;

    `include "tb_checks.svh"

    pipe_core u_dut (
        .clk(clk), .rst(rst),
        .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
        .ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Opcode 3f decodes as a nop, low bits follow the address
    function automatic word_t fill_word(word_t adr);
        return {6'h3f, adr[27:2] ^ {22'b0, adr[31:28]}};
    endfunction

    function automatic word_t gold_at(int i);
        return gold[7'(i)];
    endfunction

    function automatic word_t fetch_word(word_t adr);
        if (adr[31:8] == '0) begin
            return gold[{1'b0, adr[7:2]}];  // Program area, 64 words
        end
        return fill_word(adr);
    endfunction

    // Wishbone classic slave, registered ack after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (rst) begin
            ibus_ack <= 1'b0;
            wait_cnt <= 2'd0;
            req_num  <= 8'd0;
        end else if (ibus_ack) begin
            ibus_ack <= 1'b0;        // Master drops stb after this
            wait_cnt <= 2'd0;
            req_num  <= req_num + 8'd1;
        end else if (ibus_cyc && ibus_stb) begin
            if (wait_cnt >= delay_tab[req_num]) begin
                ibus_ack   <= 1'b1;
                ibus_dat_r <= fetch_word(ibus_adr);
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

    // Next retire at a falling edge, seen stays low on timeout
    task automatic wait_write(output bit seen);
        int cyc;
        seen = 1'b0;
        cyc  = 0;
        while (!seen && cyc < write_timeout) begin
            @(negedge clk);
            seen = rf_we;
            cyc++;
        end
    endtask

    initial begin
        int n_exp;
        int idx;
        bit seen;
        bit lost;
        void'($urandom(32'hbe8f));
        rst        <= 1'b1;
        ibus_ack   <= 1'b0;
        ibus_dat_r <= '0;
        for (idx = 0; idx < 256; idx++) begin
            delay_tab[8'(idx)] = 2'($urandom % 4);
        end
        for (idx = 0; idx < 128; idx++) begin
            gold[7'(idx)] = fill_word(word_t'(idx) << 2);
        end
        $readmemh("test/pipe_golden.txt", gold);
        n_exp = int'(gold_at(count_at));
        if (n_exp == 0) begin
            report_failure("golden file gives no expected register writes");
        end

        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_bit("ibus_cyc", ibus_cyc, 1'b0);  // Bus idle in reset
        check_bit("ibus_stb", ibus_stb, 1'b0);
        check_bit("rf_we", rf_we, 1'b0);
        @(posedge clk);
        rst <= 1'b0;

        // Writes must retire in golden order
        idx  = 0;
        lost = 1'b0;
        while (!lost && idx < n_exp) begin
            wait_write(seen);
            if (seen) begin
                check_reg("rf_waddr", rf_waddr, reg_idx_t'(gold_at(pairs_at + 2 * idx)));
                check_word("rf_wdata", rf_wdata, gold_at(pairs_at + 2 * idx + 1));
            end else begin
                report_failure($sformatf("no register write %0d of %0d before timeout",
                                         idx + 1, n_exp));
                lost = 1'b1;
            end
            idx++;
        end

        // Program ends in a jump to itself, so nothing else may retire
        for (idx = 0; idx < quiet_cycles; idx++) begin
            @(negedge clk);
            if (rf_we) begin
                report_failure($sformatf("extra register write to r%0d with %08h",
                                         rf_waddr, rf_wdata));
            end
        end

        $display("Checks run %0d, value errors %0d, other errors %0d",
                 checks_run, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && checks_run > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== test/pipe_golden.txt ====
// From index 0: program, one instruction word per line
// From index 40 hex: write count, then one write per line as register, value
20010005  // 00 addi r1, r0, 5
2002000c  // 04 addi r2, r0, 12
2003fffd  // 08 addi r3, r0, -3
2004000a  // 0c addi r4, r0, 10
00222820  // 10 add  r5, r1, r2
00223022  // 14 sub  r6, r1, r2
00443824  // 18 and  r7, r2, r4
00444025  // 1c or   r8, r2, r4
00614820  // 20 add  r9, r3, r1
200a0007  // 24 addi r10, r0, 7
014a5820  // 28 add  r11, r10, r10, distance 1
200c0064  // 2c addi r12, r0, 100
200d0001  // 30 addi r13, r0, 1
01817022  // 34 sub  r14, r12, r1, distance 2
200f0020  // 38 addi r15, r0, 32
20100002  // 3c addi r16, r0, 2
20110003  // 40 addi r17, r0, 3
01ed9025  // 44 or   r18, r15, r13, distance 3
20000009  // 48 addi r0, r0, 9
00019820  // 4c add  r19, r0, r1
11ad0002  // 50 beq  r13, r13, 5c taken
20140111  // 54 addi r20 skipped
20150222  // 58 addi r21 skipped
20160033  // 5c addi r22, r0, 0x33
10220003  // 60 beq  r1, r2 not taken
20170044  // 64 addi r23, r0, 0x44
0800001d  // 68 j    74
20180555  // 6c addi r24 skipped
20190666  // 70 addi r25 skipped
02d7d020  // 74 add  r26, r22, r23
0800001e  // 78 j    78, park here
@40
17        // 23 writes
01 00000005
02 0000000c
03 fffffffd
04 0000000a
05 00000011
06 fffffff9
07 00000008
08 0000000e
09 00000002
0a 00000007
0b 0000000e
0c 00000064
0d 00000001
0e 0000005f
0f 00000020
10 00000002
11 00000003
12 00000021
00 00000009
13 00000005
16 00000033
17 00000044
1a 00000077

// ==== compile.f ====
+incdir+test
hdl/pipe_pkg.sv
hdl/fetch_if.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/pipe_core.sv
test/tb_pipe_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator
verilator --binary --timing --assert -f compile.f --top-module tb_pipe_core \
    --Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
